// ==== common/dcache_pkg.sv ====
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

    localparam int WORD_BYTES = `DCACHE_WORD_BITS / 8;
    localparam int BYTE_OFF_BITS = $clog2(WORD_BYTES);
    localparam int OFFSET_BITS = $clog2(`DCACHE_LINE_WORDS);
    localparam int LINE_OFF_BITS = OFFSET_BITS + BYTE_OFF_BITS;
    localparam int INDEX_BITS = $clog2(`DCACHE_SETS);
    localparam int TAG_BITS = `DCACHE_ADDR_BITS - INDEX_BITS - LINE_OFF_BITS;
    localparam int LINE_ADDR_BITS = TAG_BITS + INDEX_BITS;
    localparam int WAY_BITS = $clog2(`DCACHE_WAYS);

    // Fixed AXI burst shape
    localparam logic [7:0] AXI_LEN = 8'(`DCACHE_LINE_WORDS - 1);
    localparam logic [2:0] AXI_SIZE = 3'(BYTE_OFF_BITS);
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [WORD_BYTES-1:0] AXI_STRB_FULL = '1;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [`DCACHE_WORD_BITS-1:0] word_t;
    typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;
    typedef logic [`DCACHE_WAYS-1:0] way_sel_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        DONE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        B_IDLE,
        B_ADDR,
        B_DATA,
        B_RESP
    } burst_state_t;

    function automatic index_t get_index(word_t a);
        return a[LINE_OFF_BITS +: INDEX_BITS];
    endfunction

    function automatic tag_t get_tag(word_t a);
        return a[`DCACHE_ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic offset_t get_offset(word_t a);
        return a[BYTE_OFF_BITS +: OFFSET_BITS];
    endfunction

    // Tag and index, the line-aligned address without its offset
    function automatic line_addr_t get_line_addr(word_t a);
        return a[`DCACHE_ADDR_BITS-1 -: LINE_ADDR_BITS];
    endfunction

endpackage

`default_nettype wire

// ==== common/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Data word width, also the AXI data width
`define DCACHE_WORD_BITS 32

// Words per line, equal to the AXI burst length
`define DCACHE_LINE_WORDS 8

`define DCACHE_SETS 16
`define DCACHE_WAYS 2

`define DCACHE_ADDR_BITS 32

`endif

// ==== common/line_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

interface line_mem_if import dcache_pkg::*; ();

    index_t index;
    way_sel_t tag_we;
    way_sel_t data_we;
    tag_entry_t tag_wdata;
    line_t line_wdata;

    // Registered read data, one entry per way
    tag_entry_t [`DCACHE_WAYS-1:0] tag_rdata;
    line_t [`DCACHE_WAYS-1:0] line_rdata;

    modport ctrl (
        output index, tag_we, data_we, tag_wdata, line_wdata,
        input  tag_rdata, line_rdata
    );

    modport ways (
        input  index, tag_we, data_we, tag_wdata, line_wdata,
        output tag_rdata, line_rdata
    );

endinterface

`default_nettype wire

// ==== common/line_xfer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

interface line_xfer_if import dcache_pkg::*; ();

    logic start;
    logic done;
    line_addr_t line_addr;
    // Line to send, write-back only
    line_t wline;
    // Assembled line, refill only, valid while done is high
    line_t rline;

    modport ctrl (output start, line_addr, wline, input done, rline);

    modport engine (input start, line_addr, wline, output done, rline);

endinterface

`default_nettype wire

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic read,
    input  logic write,
    input  word_t addr,
    input  word_t wdata,
    input  logic [WORD_BYTES-1:0] byteenable,
    output logic stall,
    output word_t rdata,
    line_mem_if.ctrl mem,
    line_xfer_if.ctrl refill,
    line_xfer_if.ctrl wb
);

    ctrl_state_t state, state_d;
    index_t init_idx;
    logic kick;
    logic [7:0] lfsr;

    word_t req_addr;
    word_t req_wdata;
    logic [WORD_BYTES-1:0] req_be;
    logic req_write;

    way_sel_t hit_way;
    logic hit;
    line_t hit_line;
    line_t base_line;
    line_t merged_line;

    logic [WAY_BITS-1:0] draw;
    logic [WAY_BITS-1:0] victim_sel;
    logic [WAY_BITS-1:0] victim_way;
    logic redraw;
    logic victim_dirty;
    tag_t victim_tag;
    line_t victim_line;
    word_t fill_word;

    // Most recent refill, protected from being the next victim in its set
    logic last_fill_valid;
    line_addr_t last_fill_addr;
    logic [WAY_BITS-1:0] last_fill_way;

    logic refill_busy;
    logic wb_busy;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(logic [7:0] v);
        return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word,
                                          logic [WORD_BYTES-1:0] be);
        word_t result;
        result = old_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Tag compare
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_way[w] = mem.tag_rdata[w].valid && mem.tag_rdata[w].tag == get_tag(req_addr);
            if (hit_way[w]) begin
                hit_line = mem.line_rdata[w];
            end
        end
    end

    assign hit = |hit_way;

    // Victim draw, moved off the line that was just refilled here
    assign draw = lfsr[WAY_BITS-1:0];
    assign redraw = last_fill_valid && draw == last_fill_way && mem.tag_rdata[draw].valid
        && last_fill_addr == {mem.tag_rdata[draw].tag, get_index(req_addr)};
    assign victim_sel = redraw ? WAY_BITS'(draw + 1'b1) : draw;
    assign victim_dirty = mem.tag_rdata[victim_sel].valid && mem.tag_rdata[victim_sel].dirty;

    // Byte merge on top of the hit line or the refilled line
    assign base_line = (state == REFILL) ? refill.rline : hit_line;

    always_comb begin
        merged_line = base_line;
        merged_line[get_offset(req_addr)] =
            merge_bytes(base_line[get_offset(req_addr)], req_wdata, req_be);
    end

    always_comb begin
        case (state)
            INIT: mem.index = init_idx;
            IDLE: mem.index = get_index(addr);
            default: mem.index = get_index(req_addr);
        endcase
    end

    always_comb begin
        mem.tag_we = '0;
        mem.data_we = '0;
        mem.tag_wdata = '{valid: 1'b1, dirty: req_write, tag: get_tag(req_addr)};
        mem.line_wdata = req_write ? merged_line : base_line;
        if (state == INIT) begin
            mem.tag_we = '1;
            mem.tag_wdata = '0;
        end else if (state == LOOKUP && hit && req_write) begin
            mem.tag_we = hit_way;
            mem.data_we = hit_way;
        end else if (state == REFILL && refill.done) begin
            mem.tag_we = way_sel_t'(1) << victim_way;
            mem.data_we = way_sel_t'(1) << victim_way;
        end
    end

    always_comb begin
        state_d = state;
        case (state)
            INIT: if (init_idx == index_t'(`DCACHE_SETS - 1)) state_d = IDLE;
            IDLE: if (read || write) state_d = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: if (wb.done) state_d = REFILL;
            REFILL: if (refill.done) state_d = DONE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INIT;
            init_idx <= '0;
            kick <= 1'b0;
            lfsr <= 8'h01;
            req_write <= 1'b0;
            last_fill_valid <= 1'b0;
            refill_busy <= 1'b0;
            wb_busy <= 1'b0;
        end else begin
            state <= state_d;
            // One-cycle start on entry to a burst state
            kick <= state_d != state && (state_d == WRITEBACK || state_d == REFILL);
            if (state == INIT) begin
                init_idx <= init_idx + 1'b1;
            end
            if (state == IDLE && (read || write)) begin
                req_write <= write;
            end
            if (state == LOOKUP && !hit) begin
                lfsr <= redraw ? lfsr_step(lfsr_step(lfsr)) : lfsr_step(lfsr);
            end
            if (state == REFILL && refill.done) begin
                last_fill_valid <= 1'b1;
            end
            if (refill.start) begin
                refill_busy <= 1'b1;
            end else if (refill.done) begin
                refill_busy <= 1'b0;
            end
            if (wb.start) begin
                wb_busy <= 1'b1;
            end else if (wb.done) begin
                wb_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && (read || write)) begin
            req_addr <= addr;
            req_wdata <= wdata;
            req_be <= byteenable;
        end
        if (state == LOOKUP && !hit) begin
            victim_way <= victim_sel;
            victim_tag <= mem.tag_rdata[victim_sel].tag;
            victim_line <= mem.line_rdata[victim_sel];
        end
        if (state == REFILL && refill.done) begin
            fill_word <= refill.rline[get_offset(req_addr)];
            last_fill_addr <= get_line_addr(req_addr);
            last_fill_way <= victim_way;
        end
    end

    assign stall = !((state == LOOKUP && hit) || state == DONE);
    assign rdata = (state == DONE) ? fill_word : hit_line[get_offset(req_addr)];

    assign wb.start = kick && state == WRITEBACK;
    assign wb.line_addr = {victim_tag, get_index(req_addr)};
    assign wb.wline = victim_line;

    assign refill.start = kick && state == REFILL;
    assign refill.line_addr = get_line_addr(req_addr);

    // Write-back and refill never share the bus
    assert property (@(posedge clk) disable iff (rst) refill.start |-> !wb_busy);
    assert property (@(posedge clk) disable iff (rst) wb.start |-> !refill_busy);

    // Completion only on a hit or right after the refill burst ended
    assert property (@(posedge clk) disable iff (rst)
        !stall |-> (state == LOOKUP && hit) || (state == DONE && $past(refill.done)));

endmodule

`default_nettype wire

// ==== dcache/dcache_refill.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_refill import dcache_pkg::*; (
    input  logic clk,
    input  logic rst,
    line_xfer_if.engine xfer,
    output word_t araddr,
    output logic arvalid,
    output logic [7:0] arlen,
    input  logic arready,
    input  word_t rdata,
    input  logic rvalid,
    input  logic rlast,
    output logic rready
);

    burst_state_t state;
    offset_t beat;
    logic done_q;
    line_addr_t addr_q;
    line_t line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= B_IDLE;
            beat <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                B_IDLE: if (xfer.start) state <= B_ADDR;
                B_ADDR: begin
                    if (arready) begin
                        state <= B_DATA;
                        beat <= '0;
                    end
                end
                B_DATA: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state <= B_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == B_IDLE && xfer.start) begin
            addr_q <= xfer.line_addr;
        end
        if (state == B_DATA && rvalid) begin
            line_q[beat] <= rdata;
        end
    end

    assign araddr = {addr_q, {LINE_OFF_BITS{1'b0}}};
    assign arvalid = state == B_ADDR;
    assign arlen = AXI_LEN;
    assign rready = state == B_DATA;

    assign xfer.done = done_q;
    assign xfer.rline = line_q;

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // Memory side ends the burst exactly on the last word of the line
    assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && rlast |-> beat == offset_t'(`DCACHE_LINE_WORDS - 1));

endmodule

`default_nettype wire

// ==== dcache/dcache_ways.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_ways import dcache_pkg::*; (
    input logic clk,
    input logic rst,
    line_mem_if.ways mem
);

    tag_entry_t tag_ram [`DCACHE_WAYS][`DCACHE_SETS];
    line_t line_ram [`DCACHE_WAYS][`DCACHE_SETS];

    // Read-first arrays, all ways share the index
    always_ff @(posedge clk) begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (mem.tag_we[w]) begin
                tag_ram[w][mem.index] <= mem.tag_wdata;
            end
            if (mem.data_we[w]) begin
                line_ram[w][mem.index] <= mem.line_wdata;
            end
            mem.tag_rdata[w] <= tag_ram[w][mem.index];
            mem.line_rdata[w] <= line_ram[w][mem.index];
        end
    end

    // Only the init sweep writes several ways, and it writes invalid tags
    assert property (@(posedge clk) disable iff (rst)
        mem.tag_wdata.valid |-> $onehot0(mem.tag_we));

endmodule

`default_nettype wire

// ==== dcache/dcache_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_writeback import dcache_pkg::*; (
    input  logic clk,
    input  logic rst,
    line_xfer_if.engine xfer,
    output word_t awaddr,
    output logic awvalid,
    output logic [7:0] awlen,
    input  logic awready,
    output word_t wdata,
    output logic wvalid,
    output logic wlast,
    input  logic wready,
    input  logic bvalid,
    output logic bready
);

    burst_state_t state;
    offset_t beat;
    logic done_q;
    line_addr_t addr_q;
    line_t line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= B_IDLE;
            beat <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                B_IDLE: if (xfer.start) state <= B_ADDR;
                B_ADDR: begin
                    if (awready) begin
                        state <= B_DATA;
                        beat <= '0;
                    end
                end
                B_DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (wlast) state <= B_RESP;
                    end
                end
                B_RESP: begin
                    if (bvalid) begin
                        state <= B_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // Line and address held for the whole burst
    always_ff @(posedge clk) begin
        if (state == B_IDLE && xfer.start) begin
            addr_q <= xfer.line_addr;
            line_q <= xfer.wline;
        end
    end

    assign awaddr = {addr_q, {LINE_OFF_BITS{1'b0}}};
    assign awvalid = state == B_ADDR;
    assign awlen = AXI_LEN;
    assign wdata = line_q[beat];
    assign wvalid = state == B_DATA;
    // Beat counter wraps to zero once the last beat is taken
    assign wlast = beat == offset_t'(`DCACHE_LINE_WORDS - 1);
    assign bready = state == B_RESP;

    assign xfer.done = done_q;

    assert property (@(posedge clk) disable iff (rst) wlast |-> wvalid);

    // No data beat after the last one was taken
    assert property (@(posedge clk) disable iff (rst)
        wvalid && wready && wlast |=> !wvalid);

endmodule

`default_nettype wire

// ==== dcache_top.f ====
+incdir+common
common/dcache_pkg.sv
common/line_mem_if.sv
common/line_xfer_if.sv
dcache/dcache_ways.sv
dcache/dcache_ctrl.sv
dcache/dcache_refill.sv
dcache/dcache_writeback.sv
source/dcache_top.sv
sim/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f dcache_top.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int NUM_RANDOM = 3000;
    localparam int CONFLICT_LINES = 8;
    localparam int NUM_REQUESTS = NUM_RANDOM + 2 * CONFLICT_LINES;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 200;
    localparam int MEM_WORDS = 16384;
    localparam int LINE_WORDS = 8;

    logic clk = 1'b0;
    logic rst;

    logic read;
    logic write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] byteenable;
    logic stall;
    logic [31:0] rdata;

    logic [31:0] axi_araddr;
    logic axi_arvalid;
    logic [7:0] axi_arlen;
    logic [2:0] axi_arsize;
    logic [1:0] axi_arburst;
    logic axi_arready;
    logic [31:0] axi_rdata;
    logic axi_rvalid;
    logic axi_rlast;
    logic axi_rready;
    logic [31:0] axi_awaddr;
    logic axi_awvalid;
    logic [7:0] axi_awlen;
    logic [2:0] axi_awsize;
    logic [1:0] axi_awburst;
    logic axi_awready;
    logic [31:0] axi_wdata;
    logic [3:0] axi_wstrb;
    logic axi_wvalid;
    logic axi_wlast;
    logic axi_wready;
    logic axi_bvalid;
    logic axi_bready;

    // Memory behind the AXI bus and the CPU's view of the same memory
    logic [31:0] axi_mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];

    // Burst bookkeeping shared with the request checks
    int ar_count = 0;
    int aw_count = 0;
    logic rd_active = 1'b0;
    logic wr_active = 1'b0;
    logic [31:0] last_araddr = '0;
    int cycle_count = 0;

    logic [31:0] cpu_seed = 32'd57139;
    logic [31:0] rd_seed = 32'd57139 * 32'd3;
    logic [31:0] wr_seed = 32'd57139 * 32'd7;

    dcache_top dcache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .read        (read),
        .write       (write),
        .addr        (addr),
        .wdata       (wdata),
        .byteenable  (byteenable),
        .stall       (stall),
        .rdata       (rdata),
        .axi_araddr  (axi_araddr),
        .axi_arvalid (axi_arvalid),
        .axi_arlen   (axi_arlen),
        .axi_arsize  (axi_arsize),
        .axi_arburst (axi_arburst),
        .axi_arready (axi_arready),
        .axi_rdata   (axi_rdata),
        .axi_rvalid  (axi_rvalid),
        .axi_rlast   (axi_rlast),
        .axi_rready  (axi_rready),
        .axi_awaddr  (axi_awaddr),
        .axi_awvalid (axi_awvalid),
        .axi_awlen   (axi_awlen),
        .axi_awsize  (axi_awsize),
        .axi_awburst (axi_awburst),
        .axi_awready (axi_awready),
        .axi_wdata   (axi_wdata),
        .axi_wstrb   (axi_wstrb),
        .axi_wvalid  (axi_wvalid),
        .axi_wlast   (axi_wlast),
        .axi_wready  (axi_wready),
        .axi_bvalid  (axi_bvalid),
        .axi_bready  (axi_bready)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Odd multiplier keeps every word address distinct
    function automatic logic [31:0] fill_pattern(int widx);
        return (32'(widx) * 32'h9E3779B1) ^ 32'h3C5A0F96;
    endfunction

    function automatic logic [31:0] apply_byte_enables(logic [31:0] old_word,
                                                       logic [31:0] new_word,
                                                       logic [3:0] be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_word(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s expected %h actual %h", test, expected, actual));
        end
    endtask

    // Stay in the drive phase, 1 ns after the edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // One CPU request, held until the cycle with stall low
    task automatic cpu_access(input string name, input logic is_write, input logic [31:0] a,
                              input logic [31:0] d, input logic [3:0] be);
        int cycles;
        int ar_before;
        int aw_before;
        ar_before = ar_count;
        aw_before = aw_count;
        read = !is_write;
        write = is_write;
        addr = a;
        wdata = d;
        byteenable = be;
        @(posedge clk);
        compare_word({name, " single completion"}, 32'd1, 32'(stall));
        cycles = 1;
        while (stall !== 1'b0) begin
            @(posedge clk);
            cycles++;
        end
        if (!is_write) begin
            compare_word({name, " read data"}, ref_mem[a[15:2]], rdata);
        end
        compare_word({name, " bursts idle at completion"}, 32'd0,
                     {30'd0, rd_active, wr_active});
        compare_word({name, " write-backs per request"}, 32'd0,
                     32'(aw_count - aw_before > 1));
        if (ar_count == ar_before) begin
            compare_word({name, " hit latency"}, 32'd2, 32'(cycles));
        end else begin
            compare_word({name, " refills per request"}, 32'd1, 32'(ar_count - ar_before));
            compare_word({name, " refill address"}, {a[31:5], 5'd0}, last_araddr);
        end
        #1;
        read = 1'b0;
        write = 1'b0;
        if (is_write) begin
            ref_mem[a[15:2]] = apply_byte_enables(ref_mem[a[15:2]], d, be);
        end
    endtask

    // AR and R channels
    initial begin : read_responder
        axi_arready = 1'b0;
        axi_rvalid = 1'b0;
        axi_rlast = 1'b0;
        axi_rdata = '0;
        forever begin
            @(posedge clk);
            while (axi_arvalid !== 1'b1) @(posedge clk);
            #1;
            rd_seed = xorshift32(rd_seed);
            idle_cycles(int'(rd_seed[1:0]));
            axi_arready = 1'b1;
            @(posedge clk);
            compare_word("read burst arvalid held", 32'd1, 32'(axi_arvalid));
            compare_word("read burst len", 32'd7, 32'(axi_arlen));
            compare_word("read burst type", 32'd1, 32'(axi_arburst));
            compare_word("read burst size", 32'd2, 32'(axi_arsize));
            compare_word("read burst alignment", 32'd0, 32'(axi_araddr[4:0]));
            compare_word("read burst range", 32'd0, {16'd0, axi_araddr[31:16]});
            // Write-back of the victim has to be over first
            compare_word("write-back before refill", 32'd0, 32'(wr_active));
            last_araddr = axi_araddr;
            ar_count++;
            rd_active = 1'b1;
            #1;
            axi_arready = 1'b0;
            for (int beat = 0; beat < LINE_WORDS; beat++) begin
                rd_seed = xorshift32(rd_seed);
                idle_cycles(int'(rd_seed[1:0]));
                axi_rvalid = 1'b1;
                axi_rdata = axi_mem[last_araddr[15:2] + 14'(beat)];
                axi_rlast = beat == LINE_WORDS - 1;
                @(posedge clk);
                while (axi_rready !== 1'b1) @(posedge clk);
                if (beat == LINE_WORDS - 1) begin
                    rd_active = 1'b0;
                end
                #1;
                axi_rvalid = 1'b0;
                axi_rlast = 1'b0;
            end
        end
    end

    // AW, W and B channels
    initial begin : write_responder
        logic [31:0] waddr;
        axi_awready = 1'b0;
        axi_wready = 1'b0;
        axi_bvalid = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            axi_mem[14'(i)] = fill_pattern(i);
        end
        forever begin
            @(posedge clk);
            while (axi_awvalid !== 1'b1) @(posedge clk);
            #1;
            wr_seed = xorshift32(wr_seed);
            idle_cycles(int'(wr_seed[1:0]));
            axi_awready = 1'b1;
            @(posedge clk);
            compare_word("write burst awvalid held", 32'd1, 32'(axi_awvalid));
            compare_word("write burst len", 32'd7, 32'(axi_awlen));
            compare_word("write burst type", 32'd1, 32'(axi_awburst));
            compare_word("write burst size", 32'd2, 32'(axi_awsize));
            compare_word("write burst alignment", 32'd0, 32'(axi_awaddr[4:0]));
            compare_word("write burst range", 32'd0, {16'd0, axi_awaddr[31:16]});
            waddr = axi_awaddr;
            aw_count++;
            wr_active = 1'b1;
            #1;
            axi_awready = 1'b0;
            for (int beat = 0; beat < LINE_WORDS; beat++) begin
                wr_seed = xorshift32(wr_seed);
                idle_cycles(int'(wr_seed[1:0]));
                axi_wready = 1'b1;
                @(posedge clk);
                while (axi_wvalid !== 1'b1) @(posedge clk);
                compare_word("write burst wlast", 32'(beat == LINE_WORDS - 1), 32'(axi_wlast));
                compare_word("write burst strobe", 32'hF, 32'(axi_wstrb));
                // The dirty line is the CPU's latest view of that memory
                compare_word("write-back data", ref_mem[waddr[15:2] + 14'(beat)], axi_wdata);
                axi_mem[waddr[15:2] + 14'(beat)] = axi_wdata;
                #1;
                axi_wready = 1'b0;
            end
            wr_seed = xorshift32(wr_seed);
            idle_cycles(int'(wr_seed[1:0]));
            axi_bvalid = 1'b1;
            @(posedge clk);
            while (axi_bready !== 1'b1) @(posedge clk);
            compare_word("wvalid after last beat", 32'd0, 32'(axi_wvalid));
            wr_active = 1'b0;
            #1;
            axi_bvalid = 1'b0;
        end
    end

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] prev_a;
        logic [31:0] d;
        logic [3:0] be;
        logic is_write;
        rst = 1'b1;
        read = 1'b0;
        write = 1'b0;
        addr = '0;
        wdata = '0;
        byteenable = '0;
        prev_a = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[14'(i)] = fill_pattern(i);
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        // Let the tag clear sweep finish
        idle_cycles(20);

        // Half of the requests stay on the previous line to get hits
        for (int i = 0; i < NUM_RANDOM; i++) begin
            cpu_seed = xorshift32(cpu_seed);
            if (cpu_seed[31]) begin
                a = {prev_a[31:5], cpu_seed[4:2], 2'b00};
            end else begin
                a = {18'd0, cpu_seed[13:2], 2'b00};
            end
            is_write = cpu_seed[30];
            be = cpu_seed[29:26];
            if (be == 4'd0) begin
                be = 4'hF;
            end
            cpu_seed = xorshift32(cpu_seed);
            d = cpu_seed;
            cpu_access(is_write ? "random write" : "random read", is_write, a, d, be);
            prev_a = a;
        end

        // Lines of one set, far more than the ways
        for (int k = 0; k < CONFLICT_LINES; k++) begin
            cpu_seed = xorshift32(cpu_seed);
            cpu_access("conflict write", 1'b1, 32'h44 + 32'(k) * 32'h200, cpu_seed, 4'hF);
        end
        for (int k = 0; k < CONFLICT_LINES; k++) begin
            cpu_access("conflict read", 1'b0, 32'h44 + 32'(k) * 32'h200, 32'd0, 4'h0);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  logic clk,
    input  logic rst,
    // CPU data port
    input  logic read,
    input  logic write,
    input  word_t addr,
    input  word_t wdata,
    input  logic [`DCACHE_WORD_BITS/8-1:0] byteenable,
    output logic stall,
    output word_t rdata,
    // AXI read
    output word_t axi_araddr,
    output logic axi_arvalid,
    output logic [7:0] axi_arlen,
    output logic [2:0] axi_arsize,
    output logic [1:0] axi_arburst,
    input  logic axi_arready,
    input  word_t axi_rdata,
    input  logic axi_rvalid,
    input  logic axi_rlast,
    output logic axi_rready,
    // AXI write
    output word_t axi_awaddr,
    output logic axi_awvalid,
    output logic [7:0] axi_awlen,
    output logic [2:0] axi_awsize,
    output logic [1:0] axi_awburst,
    input  logic axi_awready,
    output word_t axi_wdata,
    output logic [`DCACHE_WORD_BITS/8-1:0] axi_wstrb,
    output logic axi_wvalid,
    output logic axi_wlast,
    input  logic axi_wready,
    input  logic axi_bvalid,
    output logic axi_bready
);

    line_mem_if mem_bus ();
    line_xfer_if refill_xfer ();
    line_xfer_if wb_xfer ();

    assign axi_arsize = AXI_SIZE;
    assign axi_arburst = AXI_BURST_INCR;
    assign axi_awsize = AXI_SIZE;
    assign axi_awburst = AXI_BURST_INCR;
    assign axi_wstrb = AXI_STRB_FULL;

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .read       (read),
        .write      (write),
        .addr       (addr),
        .wdata      (wdata),
        .byteenable (byteenable),
        .stall      (stall),
        .rdata      (rdata),
        .mem        (mem_bus.ctrl),
        .refill     (refill_xfer.ctrl),
        .wb         (wb_xfer.ctrl)
    );

    dcache_ways u_ways (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus.ways)
    );

    dcache_refill u_refill (
        .clk     (clk),
        .rst     (rst),
        .xfer    (refill_xfer.engine),
        .araddr  (axi_araddr),
        .arvalid (axi_arvalid),
        .arlen   (axi_arlen),
        .arready (axi_arready),
        .rdata   (axi_rdata),
        .rvalid  (axi_rvalid),
        .rlast   (axi_rlast),
        .rready  (axi_rready)
    );

    dcache_writeback u_writeback (
        .clk     (clk),
        .rst     (rst),
        .xfer    (wb_xfer.engine),
        .awaddr  (axi_awaddr),
        .awvalid (axi_awvalid),
        .awlen   (axi_awlen),
        .awready (axi_awready),
        .wdata   (axi_wdata),
        .wvalid  (axi_wvalid),
        .wlast   (axi_wlast),
        .wready  (axi_wready),
        .bvalid  (axi_bvalid),
        .bready  (axi_bready)
    );

endmodule

`default_nettype wire
